// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// datapath and memory geometry
	localparam int XLEN = 16;
	localparam int REG_AW = 3;
	localparam int IMEM_AW = 8;
	localparam int DMEM_AW = 8;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	// major opcode in instr[15:12]
	typedef enum logic [3:0] {
		OP_ADI  = 4'b0000,
		OP_ADD  = 4'b0001,
		OP_NAND = 4'b0010,
		OP_LHI  = 4'b0011,
		OP_LW   = 4'b0100,
		OP_SW   = 4'b0101,
		OP_NOP  = 4'b0111,
		OP_BEQ  = 4'b1000,
		OP_JAL  = 4'b1001,
		OP_JLR  = 4'b1010
	} opcode_t;

	localparam word_t NOP_INSTR = {OP_NOP, 12'h000};

	typedef enum logic {ALU_ADD, ALU_NAND} alu_op_t;

	// operand source, register file value unless a younger result is in flight
	typedef enum logic [1:0] {FWD_RF, FWD_EX_MEM, FWD_MEM_WB} fwd_sel_t;

	typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM6, SRC_B_ZERO} src_b_t;

	// destination field: rc [5:3], ra [11:9], rb [8:6]
	typedef enum logic [1:0] {DEST_RC, DEST_RA, DEST_RB} dest_sel_t;

	typedef enum logic [1:0] {WB_ALU, WB_LHI, WB_PC1} wb_sel_t;

	// all-zero control word is a bubble
	typedef struct packed {
		logic      reg_write;
		logic      mem_write;
		logic      mem_to_reg;
		alu_op_t   alu_op;
		src_b_t    src_b;
		dest_sel_t dest_sel;
		wb_sel_t   wb_sel;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t pc_plus1;
		word_t instr;
		logic  valid;
	} if_id_t;

	typedef struct packed {
		word_t     pc;
		word_t     pc_plus1;
		word_t     instr;
		ctrl_t     ctrl;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t     rd1;
		word_t     rd2;
		logic      valid;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t rd;
		word_t     result;
		word_t     store_data;
		logic      valid;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t rd;
		word_t     data;
	} mem_wb_t;

	// one retired register write
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} commit_t;

endpackage

`default_nettype wire

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     enable,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// flush beats enable and clears the slot to an all-zero bubble
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			q <= '0;
		end else if (enable) begin
			q <= d;
		end
	end

	// nothing upstream may try to kill a loaded slot while the pipeline sits in reset
	a_no_flush_in_reset: assert property (@(posedge clk)
		reset |-> !(flush && enable && (d != '0)));

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           stall,
	input  logic                           id_redirect,
	input  cpu_pkg::word_t                 id_target,
	input  logic                           ex_redirect,
	input  cpu_pkg::word_t                 ex_target,
	input  logic                           imem_we,
	input  logic [cpu_pkg::IMEM_AW-1:0]    imem_addr,
	input  cpu_pkg::word_t                 imem_data,
	output cpu_pkg::if_id_t                fetched
);

	import cpu_pkg::*;

	word_t pc;
	word_t pc_plus1;
	word_t next_pc;
	word_t imem [0:(1<<IMEM_AW)-1];

	// load port, not tied to reset so a program can be loaded while held
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_data;
		end
	end

	assign pc_plus1 = pc + 16'd1;

	// older redirect first, then JAL, then hold on a load-use stall
	always_comb begin
		if (ex_redirect) begin
			next_pc = ex_target;
		end else if (id_redirect) begin
			next_pc = id_target;
		end else if (stall) begin
			next_pc = pc;
		end else begin
			next_pc = pc_plus1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	// slot behind a taken JAL becomes a NOP and never retires
	always_comb begin
		fetched.pc = pc;
		fetched.pc_plus1 = pc_plus1;
		fetched.instr = id_redirect ? NOP_INSTR : imem[pc[IMEM_AW-1:0]];
		fetched.valid = !id_redirect;
	end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  logic               clk,
	input  logic               reset,
	input  cpu_pkg::reg_addr_t ra1,
	input  cpu_pkg::reg_addr_t ra2,
	input  cpu_pkg::reg_addr_t wa,
	input  logic               we,
	input  cpu_pkg::word_t     wd,
	output cpu_pkg::word_t     rd1,
	output cpu_pkg::word_t     rd2
);

	import cpu_pkg::*;

	word_t regs [0:(1<<REG_AW)-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < (1 << REG_AW); i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rd1 = (we && (wa == ra1)) ? wd : regs[ra1];
	assign rd2 = (we && (wa == ra2)) ? wd : regs[ra2];

	a_known_waddr: assert property (@(posedge clk) disable iff (reset) we |-> !$isunknown(wa));

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  cpu_pkg::if_id_t    in,
	input  cpu_pkg::word_t     rd1,
	input  cpu_pkg::word_t     rd2,
	output cpu_pkg::reg_addr_t rs1,
	output cpu_pkg::reg_addr_t rs2,
	output cpu_pkg::id_ex_t    out,
	output logic               jal_redirect,
	output cpu_pkg::word_t     jal_target
);

	import cpu_pkg::*;

	opcode_t   opcode;
	reg_addr_t ra;
	reg_addr_t rb;
	ctrl_t     ctrl;
	logic      known;

	assign opcode = opcode_t'(in.instr[15:12]);
	assign ra = in.instr[11:9];
	assign rb = in.instr[8:6];

	// operand A is ra for the two-register forms and SW
	assign rs1 = (opcode inside {OP_ADD, OP_NAND, OP_BEQ, OP_SW}) ? ra : rb;
	// SW data comes from ra, everything else reads rb on port 2
	assign rs2 = (opcode == OP_SW) ? ra : rb;

	always_comb begin
		ctrl = '0;
		known = 1'b1;
		case (opcode)
			OP_ADD, OP_NAND: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = (opcode == OP_NAND) ? ALU_NAND : ALU_ADD;
				ctrl.src_b = SRC_B_REG;
				ctrl.dest_sel = DEST_RC;
			end
			OP_ADI: begin
				ctrl.reg_write = 1'b1;
				ctrl.src_b = SRC_B_IMM6;
				ctrl.dest_sel = DEST_RB;
			end
			OP_LHI: begin
				ctrl.reg_write = 1'b1;
				ctrl.src_b = SRC_B_ZERO;
				ctrl.dest_sel = DEST_RA;
				ctrl.wb_sel = WB_LHI;
			end
			OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.src_b = SRC_B_IMM6;
				ctrl.dest_sel = DEST_RA;
			end
			// address is operand A plus imm6
			OP_SW: begin
				ctrl.mem_write = 1'b1;
				ctrl.src_b = SRC_B_IMM6;
			end
			// link register gets pc+1
			OP_JAL, OP_JLR: begin
				ctrl.reg_write = 1'b1;
				ctrl.src_b = SRC_B_ZERO;
				ctrl.dest_sel = DEST_RA;
				ctrl.wb_sel = WB_PC1;
			end
			// BEQ compares in execute, NOP does nothing
			OP_BEQ, OP_NOP: begin
				ctrl = '0;
			end
			default: begin
				known = 1'b0;
			end
		endcase
		if (!in.valid || !known) begin
			ctrl = '0;
		end
	end

	always_comb begin
		out.pc = in.pc;
		out.pc_plus1 = in.pc_plus1;
		out.instr = in.instr;
		out.ctrl = ctrl;
		out.rs1 = rs1;
		out.rs2 = rs2;
		out.rd1 = rd1;
		out.rd2 = rd2;
		out.valid = in.valid && known;
	end

	// JAL needs no register, so it resolves here
	assign jal_redirect = in.valid && (opcode == OP_JAL);
	assign jal_target = in.pc + {{7{in.instr[8]}}, in.instr[8:0]};

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
	input  logic               clk,
	input  cpu_pkg::reg_addr_t rs1,
	input  cpu_pkg::reg_addr_t rs2,
	input  cpu_pkg::id_ex_t    id_ex,
	input  cpu_pkg::ex_mem_t   ex_mem,
	input  cpu_pkg::mem_wb_t   mem_wb,
	output cpu_pkg::fwd_sel_t  fwd_a,
	output cpu_pkg::fwd_sel_t  fwd_b,
	output logic               stall
);

	import cpu_pkg::*;

	logic ex_mem_writes;
	logic load_in_ex;

	// youngest producer wins
	function automatic fwd_sel_t pick_source(input reg_addr_t rs, input logic em_wr,
			input reg_addr_t em_rd, input logic mw_wr, input reg_addr_t mw_rd);
		if (em_wr && (em_rd == rs)) begin
			return FWD_EX_MEM;
		end else if (mw_wr && (mw_rd == rs)) begin
			return FWD_MEM_WB;
		end
		return FWD_RF;
	endfunction

	assign ex_mem_writes = ex_mem.valid && ex_mem.ctrl.reg_write;

	assign fwd_a = pick_source(id_ex.rs1, ex_mem_writes, ex_mem.rd, mem_wb.reg_write, mem_wb.rd);
	assign fwd_b = pick_source(id_ex.rs2, ex_mem_writes, ex_mem.rd, mem_wb.reg_write, mem_wb.rd);

	// only LW sets mem_to_reg, and its destination is always ra
	assign load_in_ex = id_ex.valid && id_ex.ctrl.mem_to_reg;
	assign stall = load_in_ex && ((id_ex.instr[11:9] == rs1) || (id_ex.instr[11:9] == rs2));

	// the stall turns ID/EX into a bubble, so it cannot repeat
	a_single_stall: assert property (@(posedge clk) stall |=> !stall);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  cpu_pkg::id_ex_t   in,
	input  cpu_pkg::fwd_sel_t fwd_a,
	input  cpu_pkg::fwd_sel_t fwd_b,
	input  cpu_pkg::word_t    ex_mem_result,
	input  cpu_pkg::word_t    mem_wb_data,
	output cpu_pkg::ex_mem_t  out,
	output logic              ex_redirect,
	output cpu_pkg::word_t    ex_target
);

	import cpu_pkg::*;

	opcode_t   opcode;
	word_t     op_a;
	word_t     op_b;
	word_t     imm6_sx;
	word_t     alu_b;
	word_t     alu_y;
	word_t     lhi_val;
	word_t     wb_val;
	reg_addr_t dest;
	logic      beq_taken;

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t rf_val,
			input word_t ex_val, input word_t wb_val_in);
		case (sel)
			FWD_EX_MEM: return ex_val;
			FWD_MEM_WB: return wb_val_in;
			default: return rf_val;
		endcase
	endfunction

	assign opcode = opcode_t'(in.instr[15:12]);

	// operands after bypass
	assign op_a = fwd_mux(fwd_a, in.rd1, ex_mem_result, mem_wb_data);
	assign op_b = fwd_mux(fwd_b, in.rd2, ex_mem_result, mem_wb_data);

	assign imm6_sx = {{10{in.instr[5]}}, in.instr[5:0]};
	assign lhi_val = {in.instr[8:0], 7'b0000000};

	always_comb begin
		case (in.ctrl.src_b)
			SRC_B_IMM6: alu_b = imm6_sx;
			SRC_B_ZERO: alu_b = '0;
			default: alu_b = op_b;
		endcase
	end

	assign alu_y = (in.ctrl.alu_op == ALU_NAND) ? ~(op_a & alu_b) : (op_a + alu_b);

	always_comb begin
		case (in.ctrl.dest_sel)
			DEST_RA: dest = in.instr[11:9];
			DEST_RB: dest = in.instr[8:6];
			default: dest = in.instr[5:3];
		endcase
	end

	always_comb begin
		case (in.ctrl.wb_sel)
			WB_LHI: wb_val = lhi_val;
			WB_PC1: wb_val = in.pc_plus1;
			default: wb_val = alu_y;
		endcase
	end

	// LW keeps its address in result, memory swaps in the loaded word
	always_comb begin
		out.ctrl = in.ctrl;
		out.rd = dest;
		out.result = wb_val;
		out.store_data = op_b;
		out.valid = in.valid;
	end

	// BEQ and JLR resolve here; top flushes the two younger slots
	assign beq_taken = (opcode == OP_BEQ) && (op_a == op_b);
	assign ex_redirect = in.valid && (beq_taken || (opcode == OP_JLR));
	assign ex_target = (opcode == OP_JLR) ? op_b : (in.pc + imm6_sx);

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  logic             clk,
	input  cpu_pkg::ex_mem_t in,
	output cpu_pkg::mem_wb_t out
);

	import cpu_pkg::*;

	word_t               dmem [0:(1<<DMEM_AW)-1];
	logic [DMEM_AW-1:0]  addr;
	word_t               load_data;

	// upper address bits are ignored
	assign addr = in.result[DMEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (in.valid && in.ctrl.mem_write) begin
			dmem[addr] <= in.store_data;
		end
	end

	assign load_data = dmem[addr];

	always_comb begin
		out.reg_write = in.valid && in.ctrl.reg_write;
		out.rd = in.rd;
		out.data = in.ctrl.mem_to_reg ? load_data : in.result;
	end

endmodule

`default_nettype wire

// ==== rtl/pipelined_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelined_processor (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        imem_we,
	input  logic [cpu_pkg::IMEM_AW-1:0] imem_addr,
	input  cpu_pkg::word_t              imem_data,
	output cpu_pkg::commit_t            commit
);

	import cpu_pkg::*;

	if_id_t    fetched;
	if_id_t    if_id_q;
	id_ex_t    decoded;
	id_ex_t    id_ex_q;
	ex_mem_t   executed;
	ex_mem_t   ex_mem_q;
	mem_wb_t   mem_out;
	mem_wb_t   mem_wb_q;
	word_t     rf_rd1;
	word_t     rf_rd2;
	word_t     jal_target;
	word_t     ex_target;
	reg_addr_t rs1;
	reg_addr_t rs2;
	logic      jal_redirect;
	logic      ex_redirect;
	logic      stall;
	fwd_sel_t  fwd_a;
	fwd_sel_t  fwd_b;

	fetch_stage if_stage (
		.clk(clk), .reset(reset), .stall(stall),
		.id_redirect(jal_redirect), .id_target(jal_target),
		.ex_redirect(ex_redirect), .ex_target(ex_target),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.fetched(fetched)
	);

	// held on a load-use stall, killed by an execute redirect
	pipe_reg #(.payload_t(if_id_t)) if_id (
		.clk(clk), .reset(reset), .enable(!stall), .flush(ex_redirect),
		.d(fetched), .q(if_id_q)
	);

	decode_stage id_stage (
		.in(if_id_q), .rd1(rf_rd1), .rd2(rf_rd2), .rs1(rs1), .rs2(rs2),
		.out(decoded), .jal_redirect(jal_redirect), .jal_target(jal_target)
	);

	// writeback port is the MEM/WB record
	register_file rf (
		.clk(clk), .reset(reset), .ra1(rs1), .ra2(rs2),
		.wa(mem_wb_q.rd), .we(mem_wb_q.reg_write), .wd(mem_wb_q.data),
		.rd1(rf_rd1), .rd2(rf_rd2)
	);

	hazard_unit hazards (
		.clk(clk), .rs1(rs1), .rs2(rs2), .id_ex(id_ex_q), .ex_mem(ex_mem_q),
		.mem_wb(mem_wb_q), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
	);

	// a stall inserts the bubble here
	pipe_reg #(.payload_t(id_ex_t)) id_ex (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(ex_redirect || stall),
		.d(decoded), .q(id_ex_q)
	);

	execute_stage ex_stage (
		.in(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.ex_mem_result(ex_mem_q.result), .mem_wb_data(mem_wb_q.data),
		.out(executed), .ex_redirect(ex_redirect), .ex_target(ex_target)
	);

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0),
		.d(executed), .q(ex_mem_q)
	);

	memory_stage mem_stage (
		.clk(clk), .in(ex_mem_q), .out(mem_out)
	);

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb (
		.clk(clk), .reset(reset), .enable(1'b1), .flush(1'b0),
		.d(mem_out), .q(mem_wb_q)
	);

	// every register write retires in program order
	assign commit = '{valid: mem_wb_q.reg_write, rd: mem_wb_q.rd, data: mem_wb_q.data};

endmodule

`default_nettype wire

// ==== test/isa_model.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [31:0] rng_state = 32'hd4254a16;
logic [15:0] prog [0:255];
logic [15:0] m_regs [0:7];
logic [15:0] m_dmem [0:255];
bit          m_dvalid [0:255];
logic [2:0]  exp_rd [$];
logic [15:0] exp_data [$];
bit          recording;
int          gen_pc;

function automatic logic [31:0] xorshift32();
	logic [31:0] x;
	x = rng_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rng_state = x;
	return x;
endfunction

function automatic int rand_below(input int n);
	return int'(xorshift32() % 32'(n));
endfunction

function automatic void clear_model_memory();
	for (int i = 0; i < 256; i++) begin
		m_dvalid[i] = 1'b0;
		m_dmem[i] = 16'h0000;
	end
endfunction

function automatic void write_reg(input logic [2:0] r, input logic [15:0] v);
	m_regs[r] = v;
	if (recording) begin
		exp_rd.push_back(r);
		exp_data.push_back(v);
	end
endfunction

// execute one ISA instruction and return the next pc
function automatic int exec_instr(input int pc, input logic [15:0] ins);
	logic [2:0]  ra;
	logic [2:0]  rb;
	logic [2:0]  rc;
	logic [15:0] imm6;
	logic [15:0] imm9;
	logic [15:0] pc16;
	logic [15:0] nxt;
	logic [15:0] a;
	ra = ins[11:9];
	rb = ins[8:6];
	rc = ins[5:3];
	imm6 = {{10{ins[5]}}, ins[5:0]};
	imm9 = {{7{ins[8]}}, ins[8:0]};
	pc16 = 16'(pc);
	nxt = pc16 + 16'd1;
	case (ins[15:12])
		// ADI adds to rb in place
		4'h0: write_reg(rb, m_regs[rb] + imm6);
		4'h1: write_reg(rc, m_regs[ra] + m_regs[rb]);
		4'h2: write_reg(rc, ~(m_regs[ra] & m_regs[rb]));
		4'h3: write_reg(ra, {ins[8:0], 7'b0000000});
		4'h4: begin
			a = m_regs[rb] + imm6;
			write_reg(ra, m_dmem[a[7:0]]);
		end
		// SW stores ra at ra plus imm6
		4'h5: begin
			a = m_regs[ra] + imm6;
			m_dmem[a[7:0]] = m_regs[ra];
			m_dvalid[a[7:0]] = 1'b1;
		end
		4'h8: begin
			if (m_regs[ra] == m_regs[rb]) begin
				nxt = pc16 + imm6;
			end
		end
		4'h9: begin
			write_reg(ra, pc16 + 16'd1);
			nxt = pc16 + imm9;
		end
		// target read before the link write
		4'hA: begin
			a = m_regs[rb];
			write_reg(ra, pc16 + 16'd1);
			nxt = a;
		end
		default: begin
		end
	endcase
	return int'(nxt);
endfunction

function automatic logic [15:0] random_alu();
	logic [2:0] ra;
	logic [2:0] rb;
	logic [2:0] rc;
	int sel;
	// registers 0 to 3 only, so results get reused quickly
	ra = 3'(rand_below(4));
	rb = 3'(rand_below(4));
	rc = 3'(rand_below(4));
	sel = rand_below(4);
	case (sel)
		0: return {4'h1, ra, rb, rc, 3'b000};
		1: return {4'h2, ra, rb, rc, 3'b000};
		2: return {4'h0, ra, rb, 6'(rand_below(64))};
		default: return {4'h3, ra, 9'(rand_below(512))};
	endcase
endfunction

// place and execute one instruction and fill any skipped words with junk
function automatic void emit(input logic [15:0] ins);
	int nxt;
	prog[gen_pc] = ins;
	nxt = exec_instr(gen_pc, ins);
	for (int a = gen_pc + 1; a < nxt; a++) begin
		prog[a] = random_alu();
	end
	gen_pc = nxt;
endfunction

function automatic void emit_mem(input int n);
	logic [2:0]  ra;
	logic [2:0]  rb;
	logic [5:0]  off;
	logic [15:0] a;
	int          start;
	bit          found;
	ra = 3'(rand_below(4));
	rb = 3'(rand_below(4));
	start = rand_below(64);
	found = 1'b0;
	off = 6'(start);
	// look for an offset that reaches a word already stored
	for (int k = 0; k < 64; k++) begin
		off = 6'(start + k);
		a = m_regs[rb] + {{10{off[5]}}, off};
		if (m_dvalid[a[7:0]]) begin
			found = 1'b1;
			break;
		end
	end
	if (!found || rand_below(3) == 0) begin
		emit({4'h5, ra, rb, 6'(rand_below(64))});
	end else begin
		emit({4'h4, ra, rb, off});
		// load-use pair, kept inside the program
		if (gen_pc < n && rand_below(2) == 0) begin
			emit({4'h1, ra, 3'(rand_below(4)), 3'(rand_below(4)), 3'b000});
		end
	end
endfunction
`endif

// ==== test/tb_processor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_processor;

	import cpu_pkg::*;

	logic        clk;
	logic        reset;
	logic        imem_we;
	logic [7:0]  imem_addr;
	logic [15:0] imem_data;
	commit_t     commit;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_count = 0;
	int test_start = 0;
	int cycle_limit = 400;

	`include "isa_model.svh"

	pipelined_processor dut0 (
		.clk(clk),
		.reset(reset),
		.imem_we(imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.commit(commit)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog with a per-test cycle limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count - test_start > cycle_limit) begin
			$display("timeout: test ran past %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	// kind selects nop (0), alu (1), memory (2), control flow (3) or mixed (4)
	task automatic gen_program(input int kind, input int n);
		logic [15:0] save_dmem [0:255];
		bit          save_valid [0:255];
		int          cls;
		int          lim;
		int          t;
		logic [2:0]  r;
		for (int i = 0; i < 256; i++) begin
			prog[i] = 16'h7000;
			save_dmem[i] = m_dmem[i];
			save_valid[i] = m_dvalid[i];
		end
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = 16'h0000;
		end
		recording = 1'b0;
		gen_pc = 0;
		while (gen_pc < n) begin
			case (kind)
				1: cls = 0;
				2: cls = (rand_below(3) == 0) ? 0 : 1;
				3: cls = (rand_below(5) < 2) ? 0 : 1 + rand_below(3) + 1;
				default: cls = (rand_below(6) < 2) ? 0 : 1 + rand_below(4);
			endcase
			lim = (n - gen_pc < 31) ? n - gen_pc : 31;
			if (cls == 1) begin
				emit_mem(n);
			end else if (cls == 2) begin
				// same register half the time, so taken branches are common
				r = 3'(rand_below(4));
				emit({4'h8, r, (rand_below(2) == 0) ? r : 3'(rand_below(4)),
					6'(1 + rand_below(lim))});
			end else if (cls == 3) begin
				emit({4'h9, 3'(rand_below(8)), 9'(1 + rand_below(n - gen_pc))});
			end else if (cls == 4 && gen_pc + 3 <= ((n < 31) ? n : 31)) begin
				// LHI clears rb, ADI sets the target, JLR jumps there
				t = gen_pc + 3 + rand_below(((n < 31) ? n : 31) - gen_pc - 2);
				r = 3'(4 + rand_below(4));
				emit({4'h3, r, 9'd0});
				emit({4'h0, 3'b000, r, 6'(t)});
				emit({4'hA, 3'(rand_below(8)), r, 6'b000000});
			end else begin
				emit(random_alu());
			end
		end
		for (int i = 0; i < 256; i++) begin
			m_dmem[i] = save_dmem[i];
			m_dvalid[i] = save_valid[i];
		end
	endtask

	// replay the finished program from pc 0 and queue its register writes
	task automatic run_model(input int n);
		int pc;
		int steps;
		for (int i = 0; i < 8; i++) begin
			m_regs[i] = 16'h0000;
		end
		exp_rd.delete();
		exp_data.delete();
		recording = 1'b1;
		pc = 0;
		steps = 0;
		while (pc < n && steps < 256) begin
			pc = exec_instr(pc, prog[pc]);
			steps++;
		end
		recording = 1'b0;
	endtask

	task automatic check_commit();
		logic [2:0]  e_rd;
		logic [15:0] e_data;
		e_rd = exp_rd.pop_front();
		e_data = exp_data.pop_front();
		assert (commit.rd == e_rd) else begin
			$display("FAIL commit.rd expected %h got %h", e_rd, commit.rd);
			errors++;
		end
		assert (commit.data == e_data) else begin
			$display("FAIL commit.data expected %h got %h", e_data, commit.data);
			errors++;
		end
	endtask

	task automatic run_test(input string name, input int kind, input int n);
		int errors_before;
		int commits;
		errors_before = errors;
		commits = 0;
		gen_program(kind, n);
		run_model(n);
		test_start = cycle_count;
		cycle_limit = 6 * n + 300;
		@(posedge clk);
		#1;
		reset = 1'b1;
		// load all 256 words because unwritten memory is undefined
		for (int k = 0; k < 256; k++) begin
			imem_we = 1'b1;
			imem_addr = k[7:0];
			imem_data = prog[k];
			@(posedge clk);
			#1;
		end
		imem_we = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		while (exp_rd.size() > 0) begin
			@(negedge clk);
			if (commit.valid) begin
				check_commit();
				commits++;
			end
		end
		// nothing more may retire once the program has left
		repeat (20) begin
			@(negedge clk);
			assert (!commit.valid) else begin
				$display("unexpected commit to r%0d after the program finished", commit.rd);
				errors++;
			end
		end
		tests_run++;
		if (errors == errors_before) begin
			$display("%s: ok, %0d commits", name, commits);
		end else begin
			tests_failed++;
			$display("%s: %0d errors, %0d commits", name, errors - errors_before, commits);
		end
	endtask

	initial begin
		reset = 1'b1;
		imem_we = 1'b0;
		imem_addr = 8'h00;
		imem_data = 16'h7000;
		clear_model_memory();
		run_test("nop program", 0, 0);
		run_test("alu forwarding", 1, 32);
		run_test("load store", 2, 32);
		run_test("control flow a", 3, 32);
		run_test("control flow b", 3, 32);
		for (int i = 0; i < 10; i++) begin
			run_test($sformatf("mixed %0d", i), 4, 20 + rand_below(13));
		end
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/cpu_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/hazard_unit.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/pipelined_processor.sv
+incdir+test
test/tb_processor.sv

// ==== run.sh ====
#!/bin/sh
# build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_processor -f all.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
